/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - include

sources:
  - files:
      - verilog/dcache_pkg.sv
      - verilog/tag_store.sv
      - verilog/data_store.sv
      - verilog/plru_tree.sv
      - verilog/cache_ctrl.sv
      - verilog/dcache_top.sv
  - target: test
    files:
      - tests/dcache_sva.sv
      - tests/tb_dcache.sv

/* flist.f */
+incdir+include
verilog/dcache_pkg.sv
verilog/tag_store.sv
verilog/data_store.sv
verilog/plru_tree.sv
verilog/cache_ctrl.sv
verilog/dcache_top.sv
tests/dcache_sva.sv
tests/tb_dcache.sv

/* include/dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// words of 32 bits in one cache line, power of two
`define DC_WORDS_PER_LINE 8

// associativity, 2 or 4
`define DC_WAYS 4

// total data capacity in bytes
// 2048 bytes with 8-word lines and 4 ways gives 16 sets
`define DC_CACHE_BYTES 2048

// byte address width on both the CPU and memory side
`define DC_ADDR_W 32

`endif

/* tests/dcache_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_sva (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_cpu_req,
	input wire dcache_pkg::cpu_req_t i_cpu_data,
	input wire logic i_cpu_ack,
	input wire logic i_mem_req,
	input wire dcache_pkg::mem_req_t i_mem_data,
	input wire logic i_mem_ack
);
	import dcache_pkg::*;

	int sva_errors = 0;
	// cycles left in the tag sweep
	logic [INDEX_W:0] inv_left;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			inv_left <= (INDEX_W + 1)'(SETS);
		end else if (inv_left != 0) begin
			inv_left <= inv_left - 1'b1;
		end
	end

	// cpu may drop the request in the cycle the ack is seen
	cpu_req_held: assert property (@(posedge i_clk) disable iff (i_rst)
		i_cpu_req && !i_cpu_ack |=> i_cpu_ack || (i_cpu_req && $stable(i_cpu_data)))
		else begin
			$error("cpu request dropped or changed before ack");
			sva_errors++;
		end

	cpu_ack_held: assert property (@(posedge i_clk) disable iff (i_rst)
		i_cpu_ack && i_cpu_req |=> i_cpu_ack)
		else begin
			$error("cpu ack fell while the request was high");
			sva_errors++;
		end

	mem_req_held: assert property (@(posedge i_clk) disable iff (i_rst)
		i_mem_req && !i_mem_ack |=> i_mem_req && $stable(i_mem_data))
		else begin
			$error("memory request dropped or changed before ack");
			sva_errors++;
		end

	mem_ack_held: assert property (@(posedge i_clk) disable iff (i_rst)
		$fell(i_mem_ack) |-> !i_mem_req)
		else begin
			$error("memory ack fell while the request was high");
			sva_errors++;
		end

	quiet_during_sweep: assert property (@(posedge i_clk) disable iff (i_rst)
		inv_left != 0 |-> !i_cpu_ack && !i_mem_req && !i_mem_ack)
		else begin
			$error("handshake active during tag invalidation");
			sva_errors++;
		end

endmodule

bind dcache_top dcache_sva u_sva (
	.i_clk(i_clk),
	.i_rst(i_rst),
	.i_cpu_req(i_cpu_req),
	.i_cpu_data(i_cpu_data),
	.i_cpu_ack(o_cpu_ack),
	.i_mem_req(o_mem_req),
	.i_mem_data(o_mem_data),
	.i_mem_ack(i_mem_ack)
);

`default_nettype wire

/* tests/tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
	import dcache_pkg::*;

	localparam int RST_CYCLES = 4;
	// memory model covers the low 16 KB
	localparam int MEM_AW = 12;

	typedef struct packed {
		cpu_req_t req;
		logic hit;
	} op_row_t;

	logic i_clk = 1'b0;
	logic i_rst;
	logic i_cpu_req;
	cpu_req_t i_cpu_data;
	logic o_cpu_ack;
	word_t o_cpu_rdata;
	logic o_mem_req;
	mem_req_t o_mem_data;
	logic i_mem_ack;
	line_t i_mem_rline;

	op_row_t ops [$];
	word_t mem_q [2**MEM_AW];
	word_t shadow [2**MEM_AW];
	logic [TAG_W-1:0] ref_tag [SETS][WAYS];
	logic ref_valid [SETS][WAYS];
	logic [LRU_W-1:0] ref_plru [SETS];

	// transactions seen by the memory model
	int rd_count = 0;
	int wr_count = 0;
	logic [ADDR_W-1:0] rd_addr;
	logic [ADDR_W-1:0] wr_addr;
	line_t wr_line;

	int errors = 0;
	int checks = 0;
	int cycle_cnt = 0;
	int timeout_cycles = 0;

	dcache_top UUT (
		.i_clk, .i_rst,
		.i_cpu_req, .i_cpu_data, .o_cpu_ack, .o_cpu_rdata,
		.o_mem_req, .o_mem_data, .i_mem_ack, .i_mem_rline
	);

	always #2 i_clk = ~i_clk;

	function automatic word_t init_word(input logic [ADDR_W-1:0] addr);
		return (addr * 32'h9e37_79b1) ^ 32'h3c5a_a5c3;
	endfunction

	function automatic int mem_idx(input logic [ADDR_W-1:0] addr);
		return int'(addr[2 +: MEM_AW]);
	endfunction

	// walk from the root, a set bit leads to the upper half
	function automatic int plru_victim(input logic [LRU_W-1:0] bits);
		int node;
		int way;
		node = 0;
		way = 0;
		for (int l = 0; l < WAY_W; l++) begin
			way = 2 * way + int'(bits[node]);
			node = 2 * node + 1 + int'(bits[node]);
		end
		return way;
	endfunction

	function automatic logic [LRU_W-1:0] plru_touch(input logic [LRU_W-1:0] bits, input int way);
		logic [LRU_W-1:0] res;
		int node;
		logic upper;
		res = bits;
		node = 0;
		for (int l = WAY_W - 1; l >= 0; l--) begin
			upper = ((way >> l) & 1) != 0;
			// point at the other half
			res[node] = !upper;
			node = 2 * node + (upper ? 2 : 1);
		end
		return res;
	endfunction

	task automatic compare_value(input string what, input logic [$bits(line_t)-1:0] got,
			input logic [$bits(line_t)-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s mismatch, expected %0h, got %0h", $time, what, exp, got);
		end
	endtask

	task automatic add_op(input logic [ADDR_W-1:0] addr, input word_t wdata,
			input logic [3:0] be, input logic hit);
		op_row_t row;
		row.req.addr = addr;
		row.req.wdata = wdata;
		row.req.be = be;
		row.hit = hit;
		ops.push_back(row);
	endtask

	// reference cache: tags, valid bits, tree bits and the latest value of every word
	task automatic predict(input cpu_req_t req, output word_t exp_word, output logic exp_wb,
			output logic [ADDR_W-1:0] exp_wb_addr, output line_t exp_wb_line);
		int set;
		int way;
		int base;
		logic found;
		logic [TAG_W-1:0] tag;
		set = int'(req.addr[OFFSET_W +: INDEX_W]);
		tag = req.addr[ADDR_W-1 -: TAG_W];
		found = 1'b0;
		exp_wb = 1'b0;
		way = 0;
		for (int w = 0; w < WAYS; w++) begin
			if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
				found = 1'b1;
				way = w;
			end
		end
		if (!found) begin
			way = plru_victim(ref_plru[set]);
			exp_wb = ref_valid[set][way];
			exp_wb_addr = {ref_tag[set][way], req.addr[OFFSET_W +: INDEX_W], {OFFSET_W{1'b0}}};
			base = mem_idx(exp_wb_addr);
			for (int k = 0; k < WORDS_PER_LINE; k++) begin
				exp_wb_line[k] = shadow[base + k];
			end
			ref_tag[set][way] = tag;
			ref_valid[set][way] = 1'b1;
		end
		ref_plru[set] = plru_touch(ref_plru[set], way);
		for (int b = 0; b < 4; b++) begin
			if (req.be[b]) begin
				shadow[mem_idx(req.addr)][8*b +: 8] = req.wdata[8*b +: 8];
			end
		end
		exp_word = shadow[mem_idx(req.addr)];
	endtask

	task automatic run_op(input int row);
		op_row_t op;
		word_t exp_word;
		logic exp_wb;
		logic [ADDR_W-1:0] exp_wb_addr;
		line_t exp_wb_line;
		int rd0;
		int wr0;
		int err0;
		int cycles;
		op = ops[row];
		err0 = errors;
		rd0 = rd_count;
		wr0 = wr_count;
		predict(op.req, exp_word, exp_wb, exp_wb_addr, exp_wb_line);
		i_cpu_data = op.req;
		i_cpu_req = 1'b1;
		cycles = 0;
		do begin
			@(negedge i_clk);
			cycles++;
		end while (!o_cpu_ack);
		compare_value("read data", o_cpu_rdata, exp_word);
		i_cpu_req = 1'b0;
		if (op.hit) begin
			compare_value("hit latency", cycles, 2);
		end
		compare_value("refill count", rd_count - rd0, op.hit ? 0 : 1);
		if (!op.hit) begin
			compare_value("refill address", rd_addr,
				{op.req.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
		end
		compare_value("write-back count", wr_count - wr0, exp_wb ? 1 : 0);
		if (exp_wb && wr_count != wr0) begin
			compare_value("write-back address", wr_addr, exp_wb_addr);
			compare_value("write-back line", wr_line, exp_wb_line);
		end
		while (o_cpu_ack) begin
			@(negedge i_clk);
		end
		$display("op %0d addr %h be %b %s: %s", row, op.req.addr, op.req.be,
			op.hit ? "hit" : "miss", (errors == err0) ? "ok" : "FAILED");
	endtask

	// answers one line per request after 0 to 3 cycles
	initial begin : memory_model
		int delay;
		int base;
		void'($urandom(32'h13d3_3231));
		i_mem_ack = 1'b0;
		i_mem_rline = '0;
		forever begin
			@(negedge i_clk);
			if (o_mem_req) begin
				delay = int'($urandom_range(3, 0));
				repeat (delay) @(negedge i_clk);
				base = mem_idx(o_mem_data.addr);
				if (o_mem_data.cmd == MEM_WRITE) begin
					for (int k = 0; k < WORDS_PER_LINE; k++) begin
						mem_q[base + k] = o_mem_data.wline[k];
					end
					wr_addr = o_mem_data.addr;
					wr_line = o_mem_data.wline;
					wr_count++;
				end else begin
					for (int k = 0; k < WORDS_PER_LINE; k++) begin
						i_mem_rline[k] = mem_q[base + k];
					end
					rd_addr = o_mem_data.addr;
					rd_count++;
				end
				i_mem_ack = 1'b1;
				do begin
					@(negedge i_clk);
				end while (o_mem_req);
				i_mem_ack = 1'b0;
			end
		end
	end

	always @(posedge i_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (timeout_cycles > 0 && cycle_cnt >= timeout_cycles) begin
			$display("timeout: the cache did not answer within %0d cycles", timeout_cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin : main
		i_rst = 1'b1;
		i_cpu_req = 1'b0;
		i_cpu_data = '0;
		// address, write data, byte enable, expected hit
		add_op(32'h0000_0004, 32'h0000_0000, 4'b0000, 1'b0);
		add_op(32'h0000_0064, 32'h0000_0000, 4'b0000, 1'b0);
		add_op(32'h0000_0004, 32'h0000_0000, 4'b0000, 1'b1);
		add_op(32'h0000_0008, 32'hdead_beef, 4'b0011, 1'b1);
		add_op(32'h0000_0008, 32'h0000_0000, 4'b0000, 1'b1);
		add_op(32'h0000_0208, 32'h1234_5678, 4'b1100, 1'b0);
		add_op(32'h0000_0208, 32'h0000_0000, 4'b0000, 1'b1);
		add_op(32'h0000_0400, 32'h0000_0000, 4'b0000, 1'b0);
		add_op(32'h0000_0600, 32'h0000_0000, 4'b0000, 1'b0);
		add_op(32'h0000_0800, 32'h0000_0000, 4'b0000, 1'b0);
		add_op(32'h0000_0a1c, 32'h0000_0000, 4'b0000, 1'b0);
		add_op(32'h0000_0008, 32'h0000_0000, 4'b0000, 1'b0);
		add_op(32'h0000_0208, 32'h0000_0000, 4'b0000, 1'b0);
		add_op(32'h0000_0064, 32'hcafe_f00d, 4'b0100, 1'b1);
		add_op(32'h0000_0064, 32'h0000_0000, 4'b0000, 1'b1);
		add_op(32'h0000_0c10, 32'ha5a5_5a5a, 4'b1111, 1'b0);
		add_op(32'h0000_0c10, 32'h0000_0000, 4'b0000, 1'b1);
		add_op(32'h0000_0800, 32'h0000_0000, 4'b0000, 1'b0);
		add_op(32'h0000_1ffc, 32'h0000_0000, 4'b0000, 1'b0);
		add_op(32'h0000_1ffc, 32'h0000_0000, 4'b0000, 1'b1);
		timeout_cycles = ops.size() * 60 + RST_CYCLES + SETS;

		for (int i = 0; i < 2**MEM_AW; i++) begin
			mem_q[i] = init_word(ADDR_W'(i) << 2);
			shadow[i] = init_word(ADDR_W'(i) << 2);
		end
		for (int s = 0; s < SETS; s++) begin
			ref_plru[s] = '0;
			for (int w = 0; w < WAYS; w++) begin
				ref_tag[s][w] = '0;
				ref_valid[s][w] = 1'b0;
			end
		end

		repeat (RST_CYCLES) @(negedge i_clk);
		i_rst = 1'b0;

		// first request is raised during the tag sweep and must wait it out
		for (int r = 0; r < ops.size(); r++) begin
			run_op(r);
		end

		errors += UUT.u_sva.sva_errors;
		$display("%0d operations, %0d checks, %0d assertion failures, %0d errors",
			ops.size(), checks, UUT.u_sva.sva_errors, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_cpu_req,
	input wire dcache_pkg::cpu_req_t i_cpu_data,
	output logic o_cpu_ack,
	output dcache_pkg::word_t o_cpu_rdata,
	output logic o_mem_req,
	output dcache_pkg::mem_req_t o_mem_data,
	input wire logic i_mem_ack,
	input wire dcache_pkg::line_t i_mem_rline,
	output logic [dcache_pkg::INDEX_W-1:0] o_tag_index,
	output logic o_tag_we,
	output logic [dcache_pkg::WAYS-1:0] o_tag_way,
	output logic [dcache_pkg::INDEX_W-1:0] o_tag_windex,
	output dcache_pkg::tag_entry_t o_tag_wentry,
	input wire logic i_hit,
	input wire logic [dcache_pkg::WAY_W-1:0] i_hit_way,
	input wire dcache_pkg::tag_entry_t [dcache_pkg::WAYS-1:0] i_way_tags,
	output logic [dcache_pkg::INDEX_W-1:0] o_data_index,
	output logic [dcache_pkg::WORD_SEL_W-1:0] o_word_sel,
	output logic o_word_we,
	output logic [3:0] o_word_be,
	output dcache_pkg::word_t o_word_wdata,
	output logic o_line_we,
	output dcache_pkg::line_t o_line_wdata,
	input wire dcache_pkg::word_t [dcache_pkg::WAYS-1:0] i_way_words,
	input wire dcache_pkg::line_t i_victim_line,
	output logic o_lru_update,
	output logic [dcache_pkg::WAY_W-1:0] o_lru_way,
	input wire logic [dcache_pkg::WAY_W-1:0] i_victim_way
);
	import dcache_pkg::*;

	ctrl_state_e state;
	logic [INDEX_W-1:0] inv_cnt;
	// memory ack seen, waiting for it to fall
	logic mem_seen;

	cpu_req_t req_q;
	logic [WAY_W-1:0] vway_q;
	logic [TAG_W-1:0] vtag_q;
	word_t rdata_q;

	logic [INDEX_W-1:0] req_index;
	logic [TAG_W-1:0] req_tag;
	logic lookup_hit;
	logic fill_take;
	word_t fill_word;

	function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
			input logic [3:0] be);
		word_t res;
		for (int b = 0; b < 4; b++) begin
			res[8*b +: 8] = be[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
		end
		return res;
	endfunction

	assign req_index = req_q.addr[OFFSET_W +: INDEX_W];
	assign req_tag = req_q.addr[ADDR_W-1 -: TAG_W];
	assign lookup_hit = (state == ST_LOOKUP) && i_hit;
	// refill line is taken on the first cycle of ack
	assign fill_take = (state == ST_REFILL) && o_mem_req && i_mem_ack;

	// tag side, sweep writes every way of one set per cycle
	assign o_tag_index = req_index;
	assign o_tag_we = (state == ST_INVALIDATE) || fill_take;
	assign o_tag_way = (state == ST_INVALIDATE) ? '1 : WAYS'(1) << vway_q;
	assign o_tag_windex = (state == ST_INVALIDATE) ? inv_cnt : req_index;
	assign o_tag_wentry.valid = (state != ST_INVALIDATE);
	assign o_tag_wentry.tag = (state == ST_INVALIDATE) ? '0 : req_tag;

	// data side
	assign o_data_index = req_index;
	assign o_word_sel = req_q.addr[2 +: WORD_SEL_W];
	assign o_word_we = lookup_hit && (|req_q.be);
	assign o_word_be = req_q.be;
	assign o_word_wdata = req_q.wdata;
	assign o_line_we = fill_take;

	// pending store bytes go into the fetched line
	assign fill_word = merge_bytes(i_mem_rline[o_word_sel], req_q.wdata, req_q.be);
	always_comb begin
		o_line_wdata = i_mem_rline;
		o_line_wdata[o_word_sel] = fill_word;
	end

	assign o_lru_update = lookup_hit || fill_take;
	assign o_lru_way = (state == ST_LOOKUP) ? i_hit_way : vway_q;

	// write-back goes to the victim's own address
	assign o_mem_data.cmd = (state == ST_WRITEBACK) ? MEM_WRITE : MEM_READ;
	assign o_mem_data.addr = {(state == ST_WRITEBACK) ? vtag_q : req_tag,
		req_index, {OFFSET_W{1'b0}}};
	assign o_mem_data.wline = i_victim_line;

	assign o_cpu_ack = (state == ST_RESPOND);
	assign o_cpu_rdata = rdata_q;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= ST_INVALIDATE;
			inv_cnt <= '0;
			o_mem_req <= 1'b0;
			mem_seen <= 1'b0;
		end else begin
			case (state)
				ST_INVALIDATE: begin
					inv_cnt <= inv_cnt + 1'b1;
					if (inv_cnt == INDEX_W'(SETS - 1)) begin
						state <= ST_IDLE;
					end
				end
				ST_IDLE: begin
					if (i_cpu_req) begin
						state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					if (i_hit) begin
						state <= ST_RESPOND;
					end else begin
						o_mem_req <= 1'b1;
						// no dirty bits, any valid victim is written back
						state <= i_way_tags[i_victim_way].valid ? ST_WRITEBACK : ST_REFILL;
					end
				end
				ST_WRITEBACK, ST_REFILL: begin
					if (o_mem_req && i_mem_ack) begin
						o_mem_req <= 1'b0;
						mem_seen <= 1'b1;
					end else if (mem_seen && !i_mem_ack) begin
						mem_seen <= 1'b0;
						if (state == ST_WRITEBACK) begin
							o_mem_req <= 1'b1;
							state <= ST_REFILL;
						end else begin
							state <= ST_RESPOND;
						end
					end
				end
				ST_RESPOND: begin
					if (!i_cpu_req) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// miss save registers and response word
	always_ff @(posedge i_clk) begin
		if (state == ST_IDLE && i_cpu_req) begin
			req_q <= i_cpu_data;
		end
		if (state == ST_LOOKUP) begin
			vway_q <= i_victim_way;
			vtag_q <= i_way_tags[i_victim_way].tag;
		end
		// a store answers with the merged word
		if (lookup_hit) begin
			rdata_q <= merge_bytes(i_way_words[i_hit_way], req_q.wdata, req_q.be);
		end else if (fill_take) begin
			rdata_q <= fill_word;
		end
	end

endmodule

`default_nettype wire

/* verilog/data_store.sv */
`timescale 1ns/1ps
`default_nettype none

module data_store (
	input wire logic i_clk,
	input wire logic [dcache_pkg::INDEX_W-1:0] i_index,
	input wire logic [dcache_pkg::WORD_SEL_W-1:0] i_word_sel,
	input wire logic [dcache_pkg::WAY_W-1:0] i_way,
	input wire logic i_word_we,
	input wire logic [3:0] i_word_be,
	input wire dcache_pkg::word_t i_word_wdata,
	input wire logic i_line_we,
	input wire dcache_pkg::line_t i_line_wdata,
	output dcache_pkg::word_t [dcache_pkg::WAYS-1:0] o_way_words,
	output dcache_pkg::line_t o_victim_line
);
	import dcache_pkg::*;

	line_t lines [WAYS][SETS];

	// refill writes the whole line, a store hit only its enabled bytes
	always_ff @(posedge i_clk) begin
		if (i_line_we) begin
			lines[i_way][i_index] <= i_line_wdata;
		end else if (i_word_we) begin
			for (int b = 0; b < 4; b++) begin
				if (i_word_be[b]) begin
					lines[i_way][i_index][i_word_sel][8*b +: 8] <= i_word_wdata[8*b +: 8];
				end
			end
		end
	end

	// requested word of every way, for the hit mux
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			o_way_words[w] = lines[w][i_index][i_word_sel];
		end
	end

	// whole line of the selected way for write-back
	assign o_victim_line = lines[i_way][i_index];

endmodule

`default_nettype wire

/* verilog/dcache_pkg.sv */
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

	localparam int WORDS_PER_LINE = `DC_WORDS_PER_LINE;
	localparam int WAYS = `DC_WAYS;
	localparam int ADDR_W = `DC_ADDR_W;
	localparam int LINE_BYTES = WORDS_PER_LINE * 4;

	// address split: tag | index | word | byte
	localparam int OFFSET_W = $clog2(LINE_BYTES);
	localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);
	localparam int SETS = `DC_CACHE_BYTES / (LINE_BYTES * WAYS);
	localparam int INDEX_W = $clog2(SETS);
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
	localparam int WAY_W = $clog2(WAYS);
	// one tree node per internal node
	localparam int LRU_W = WAYS - 1;

	typedef logic [31:0] word_t;
	typedef word_t [WORDS_PER_LINE-1:0] line_t;

	// zero byte enable means a load
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		word_t wdata;
		logic [3:0] be;
	} cpu_req_t;

	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

	typedef enum logic {
		MEM_READ,
		MEM_WRITE
	} mem_cmd_e;

	// addr is always line aligned
	typedef struct packed {
		mem_cmd_e cmd;
		logic [ADDR_W-1:0] addr;
		line_t wline;
	} mem_req_t;

	typedef enum logic [2:0] {
		ST_INVALIDATE,
		ST_IDLE,
		ST_LOOKUP,
		ST_WRITEBACK,
		ST_REFILL,
		ST_RESPOND
	} ctrl_state_e;

endpackage

`default_nettype wire

/* verilog/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_cpu_req,
	input wire dcache_pkg::cpu_req_t i_cpu_data,
	output logic o_cpu_ack,
	output dcache_pkg::word_t o_cpu_rdata,
	output logic o_mem_req,
	output dcache_pkg::mem_req_t o_mem_data,
	input wire logic i_mem_ack,
	input wire dcache_pkg::line_t i_mem_rline
);
	import dcache_pkg::*;

	logic [INDEX_W-1:0] tag_index;
	logic tag_we;
	logic [WAYS-1:0] tag_way;
	logic [INDEX_W-1:0] tag_windex;
	tag_entry_t tag_wentry;
	logic hit;
	logic [WAY_W-1:0] hit_way;
	tag_entry_t [WAYS-1:0] way_tags;

	logic [INDEX_W-1:0] data_index;
	logic [WORD_SEL_W-1:0] word_sel;
	logic word_we;
	logic [3:0] word_be;
	word_t word_wdata;
	logic line_we;
	line_t line_wdata;
	word_t [WAYS-1:0] way_words;
	line_t victim_line;

	logic lru_update;
	logic [WAY_W-1:0] lru_way;
	logic [WAY_W-1:0] victim_way;

	cache_ctrl u_ctrl (
		.i_clk, .i_rst,
		.i_cpu_req, .i_cpu_data, .o_cpu_ack, .o_cpu_rdata,
		.o_mem_req, .o_mem_data, .i_mem_ack, .i_mem_rline,
		.o_tag_index(tag_index), .o_tag_we(tag_we), .o_tag_way(tag_way),
		.o_tag_windex(tag_windex), .o_tag_wentry(tag_wentry),
		.i_hit(hit), .i_hit_way(hit_way), .i_way_tags(way_tags),
		.o_data_index(data_index), .o_word_sel(word_sel), .o_word_we(word_we),
		.o_word_be(word_be), .o_word_wdata(word_wdata),
		.o_line_we(line_we), .o_line_wdata(line_wdata),
		.i_way_words(way_words), .i_victim_line(victim_line),
		.o_lru_update(lru_update), .o_lru_way(lru_way), .i_victim_way(victim_way)
	);

	// lookup compares against the tag field of the fill entry
	tag_store u_tags (
		.i_clk, .i_rst,
		.i_index(tag_index), .i_tag(tag_wentry.tag),
		.i_we(tag_we), .i_way(tag_way), .i_windex(tag_windex), .i_wentry(tag_wentry),
		.o_hit(hit), .o_hit_way(hit_way), .o_way_tags(way_tags)
	);

	// accessed way also selects the data way for writes and write-back reads
	data_store u_data (
		.i_clk,
		.i_index(data_index), .i_word_sel(word_sel), .i_way(lru_way),
		.i_word_we(word_we), .i_word_be(word_be), .i_word_wdata(word_wdata),
		.i_line_we(line_we), .i_line_wdata(line_wdata),
		.o_way_words(way_words), .o_victim_line(victim_line)
	);

	plru_tree u_lru (
		.i_clk, .i_rst,
		.i_index(tag_index), .i_update(lru_update), .i_way(lru_way),
		.o_victim_way(victim_way)
	);

endmodule

`default_nettype wire

/* verilog/plru_tree.sv */
`timescale 1ns/1ps
`default_nettype none

module plru_tree (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic [dcache_pkg::INDEX_W-1:0] i_index,
	input wire logic i_update,
	input wire logic [dcache_pkg::WAY_W-1:0] i_way,
	output logic [dcache_pkg::WAY_W-1:0] o_victim_way
);
	import dcache_pkg::*;

	// heap order, node n has children 2n+1 and 2n+2
	// a bit of 0 points at the lower half
	logic [LRU_W-1:0] tree_q [SETS];
	logic [LRU_W-1:0] tree_cur;
	logic [LRU_W-1:0] tree_next;

	assign tree_cur = tree_q[i_index];

	// victim: follow the bits down from the root
	always_comb begin : victim_walk
		int node;
		node = 0;
		o_victim_way = '0;
		for (int lvl = 0; lvl < WAY_W; lvl++) begin
			o_victim_way[WAY_W-1-lvl] = tree_cur[node];
			node = 2 * node + 1 + int'(tree_cur[node]);
		end
	end

	// access: every node on the path points away from the way
	always_comb begin : update_walk
		int node;
		node = 0;
		tree_next = tree_cur;
		for (int lvl = 0; lvl < WAY_W; lvl++) begin
			tree_next[node] = ~i_way[WAY_W-1-lvl];
			node = 2 * node + 1 + int'(i_way[WAY_W-1-lvl]);
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int s = 0; s < SETS; s++) begin
				tree_q[s] <= '0;
			end
		end else if (i_update) begin
			tree_q[i_index] <= tree_next;
		end
	end

endmodule

`default_nettype wire

/* verilog/tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_store (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic [dcache_pkg::INDEX_W-1:0] i_index,
	input wire logic [dcache_pkg::TAG_W-1:0] i_tag,
	input wire logic i_we,
	// way write mask
	input wire logic [dcache_pkg::WAYS-1:0] i_way,
	input wire logic [dcache_pkg::INDEX_W-1:0] i_windex,
	input wire dcache_pkg::tag_entry_t i_wentry,
	output logic o_hit,
	output logic [dcache_pkg::WAY_W-1:0] o_hit_way,
	output dcache_pkg::tag_entry_t [dcache_pkg::WAYS-1:0] o_way_tags
);
	import dcache_pkg::*;

	tag_entry_t tags [WAYS][SETS];
	logic [WAYS-1:0] way_hit;

	// no array writes while held in reset
	always_ff @(posedge i_clk) begin
		for (int w = 0; w < WAYS; w++) begin
			if (i_we && i_way[w] && !i_rst) begin
				tags[w][i_windex] <= i_wentry;
			end
		end
	end

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			o_way_tags[w] = tags[w][i_index];
		end
	end

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			way_hit[w] = o_way_tags[w].valid && (o_way_tags[w].tag == i_tag);
		end
	end

	// at most one way can match
	always_comb begin
		o_hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (way_hit[w]) begin
				o_hit_way = WAY_W'(w);
			end
		end
	end

	assign o_hit = |way_hit;

endmodule

`default_nettype wire
